// ==== all.f ====
logic/mips_ctrl_pkg.sv
logic/opcode_decoder.sv
logic/phase_controller.sv
logic/control_unit.sv
dv/control_unit_props.sv
dv/control_unit_tb.sv

// ==== dv/control_unit_props.sv ====
`timescale 1ns/10ps

module control_unit_props
    import mips_ctrl_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic pc_increment,
    input logic reg_write_enable,
    input logic mem_to_reg,
    input logic ram_read_enable,
    input logic ram_write_enable
);

    int unsigned fail_count = 0;  // Failed assertion count

    // Quiet through reset and the first cycle after release
    reset_quiet: assert property (@(posedge clk)
        reset |=> !(pc_increment || reg_write_enable || mem_to_reg
                    || ram_read_enable || ram_write_enable))
    else begin
        fail_count++;
        $error("an enable or pc_increment was high during or right after reset");
    end

    // One-cycle request, repeated every phase_count cycles
    pc_period: assert property (@(posedge clk) disable iff (reset)
        pc_increment |=> !pc_increment [*(phase_count-1)] ##1 pc_increment)
    else begin
        fail_count++;
        $error("pc_increment pulse width or period is wrong");
    end

    // Load: RAM read only at P+3, mem_to_reg through P+4
    load_window: assert property (@(posedge clk) disable iff (reset)
        ram_read_enable |-> $past(pc_increment, 3) && mem_to_reg
                            ##1 !ram_read_enable && mem_to_reg)
    else begin
        fail_count++;
        $error("ram_read_enable or mem_to_reg outside the load window");
    end

    // Store: RAM write only at P+3, no register write after it
    store_window: assert property (@(posedge clk) disable iff (reset)
        ram_write_enable |-> $past(pc_increment, 3) && !mem_to_reg
                             ##1 !ram_write_enable && !reg_write_enable)
    else begin
        fail_count++;
        $error("ram_write_enable out of place or a store wrote a register");
    end

    ram_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ram_read_enable && ram_write_enable))
    else begin
        fail_count++;
        $error("ram_read_enable and ram_write_enable high together");
    end

    // Register write lands four cycles after the request
    write_window: assert property (@(posedge clk) disable iff (reset)
        reg_write_enable |-> $past(pc_increment, 4))
    else begin
        fail_count++;
        $error("reg_write_enable high outside P+4");
    end

endmodule

bind control_unit control_unit_props u_props (.*);

// ==== dv/control_unit_tb.sv ====
`timescale 1ns/10ps

module control_unit_tb
    import mips_ctrl_pkg::*;
();

    localparam int clk_period      = 40;  // ns
    localparam int reset_cycles    = 10;
    localparam int directed_count  = 17;  // Fifteen kept opcodes plus two unknown
    localparam int random_count    = 40;
    localparam int instr_count     = directed_count + random_count;
    localparam int watchdog_cycles = reset_cycles + (instr_count + 2) * phase_count + 20;

    logic                   clk;
    logic                   reset;
    logic [instr_width-1:0] instruction;
    logic                   pc_increment;
    alu_op_t                alu_op;
    logic                   alu_src;
    logic                   reg_write_enable;
    logic                   mem_to_reg;
    logic                   ram_read_enable;
    logic                   ram_write_enable;
    reg_sel_t               reg_sel;

    int errors = 0;
    int seed   = 32'hb3ef;

    // Every opcode the unit decodes
    logic [opcode_width-1:0] kept_ops [15] = '{
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLL, OP_SRL, OP_NOR, OP_AND,
        OP_ADDI, OP_OR, OP_ORI, OP_XOR, OP_ANDI, OP_LW, OP_SW
    };
    logic [opcode_width-1:0] unknown_ops [2] = '{6'b111111, 6'b010000};

    control_unit dut (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc_increment     (pc_increment),
        .alu_op           (alu_op),
        .alu_src          (alu_src),
        .reg_write_enable (reg_write_enable),
        .mem_to_reg       (mem_to_reg),
        .ram_read_enable  (ram_read_enable),
        .ram_write_enable (ram_write_enable),
        .reg_sel          (reg_sel)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic is_rtype(input logic [opcode_width-1:0] op);
        return op inside {OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLL, OP_SRL,
                          OP_NOR, OP_AND, OP_OR, OP_XOR};
    endfunction

    function automatic logic is_immediate(input logic [opcode_width-1:0] op);
        return op inside {OP_ADDI, OP_ANDI, OP_ORI};
    endfunction

    // Expected control word, built from the instruction class
    function automatic ctrl_word_t reference_ctrl(input logic [instr_width-1:0] instr);
        logic [opcode_width-1:0] op;
        ctrl_word_t              c;
        op = instr[opcode_msb:opcode_lsb];
        c  = '0;
        case (op)
            OP_ADD, OP_ADDU, OP_ADDI, OP_LW, OP_SW: c.alu_op = ALU_ADD;  // Loads add the offset
            OP_SUB, OP_SUBU: c.alu_op = ALU_SUB;
            OP_AND, OP_ANDI: c.alu_op = ALU_AND;
            OP_OR, OP_ORI:   c.alu_op = ALU_OR;
            OP_XOR:          c.alu_op = ALU_XOR;
            OP_SLL:          c.alu_op = ALU_SLL;
            OP_SRL:          c.alu_op = ALU_SRL;
            OP_NOR:          c.alu_op = ALU_NOR;
            default:         c.alu_op = ALU_NONE;  // Bubble
        endcase
        c.alu_src    = is_immediate(op) || op == OP_LW || op == OP_SW;
        c.reg_write  = is_rtype(op) || is_immediate(op) || op == OP_LW;
        c.mem_to_reg = (op == OP_LW);
        c.ram_read   = (op == OP_LW);
        c.ram_write  = (op == OP_SW);
        return c;
    endfunction

    // Expected selects, rs and rt always, destination by class
    function automatic reg_sel_t reference_sel(input logic [instr_width-1:0] instr);
        logic [opcode_width-1:0] op;
        reg_sel_t                s;
        op                = instr[opcode_msb:opcode_lsb];
        s.read_register_1 = instr[25:21];
        s.read_register_2 = instr[20:16];
        if (is_rtype(op))
            s.write_register = instr[15:11];  // rd
        else if (is_immediate(op) || op == OP_LW)
            s.write_register = instr[20:16];  // rt
        else
            s.write_register = '0;
        return s;
    endfunction

    task automatic compare_value(input string test, input int step, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("Mismatch %s at P+%0d %s: expected %0h, actual %0h",
                     test, step, field, expected, actual);
            errors++;
        end
    endtask

    // Outputs expected in cycle P+step
    task automatic check_phase(input string test, input int step,
                               input ctrl_word_t exp_ctrl, input reg_sel_t exp_sel);
        logic exp_pc;
        logic exp_rd;
        logic exp_wr;
        logic exp_m2r;
        logic exp_we;
        exp_pc  = (step == phase_count);
        exp_rd  = (step == 3) && exp_ctrl.ram_read;
        exp_wr  = (step == 3) && exp_ctrl.ram_write;
        exp_m2r = (step == 3 || step == 4) && exp_ctrl.mem_to_reg;
        exp_we  = (step == 4) && exp_ctrl.reg_write;
        compare_value(test, step, "pc_increment", exp_pc, pc_increment);
        compare_value(test, step, "ram_read_enable", exp_rd, ram_read_enable);
        compare_value(test, step, "ram_write_enable", exp_wr, ram_write_enable);
        compare_value(test, step, "mem_to_reg", exp_m2r, mem_to_reg);
        compare_value(test, step, "reg_write_enable", exp_we, reg_write_enable);
        if (step >= 2 && step <= 4) begin  // Decoded fields held from P+2
            compare_value(test, step, "alu_op", exp_ctrl.alu_op, alu_op);
            compare_value(test, step, "alu_src", exp_ctrl.alu_src, alu_src);
            compare_value(test, step, "reg_sel", exp_sel, reg_sel);
        end
    endtask

    // Serve one fetch request and follow it through all phases
    task automatic run_instruction(input logic [instr_width-1:0] instr, input string test);
        ctrl_word_t exp_ctrl;
        reg_sel_t   exp_sel;
        exp_ctrl = reference_ctrl(instr);
        exp_sel  = reference_sel(instr);
        while (pc_increment !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);
        instruction <= instr;  // Valid in P+1
        for (int step = 1; step <= phase_count; step++) begin
            @(negedge clk);  // Mid-cycle sample
            check_phase(test, step, exp_ctrl, exp_sel);
        end
    endtask

    task automatic finish_run();
        int prop_fails;
        prop_fails = dut.u_props.fail_count;
        $display("Errors: %0d check failures, %0d assertion failures", errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Timeout: the run did not complete within %0d cycles", watchdog_cycles);
        errors++;
        finish_run();
    end

    initial begin
        logic [opcode_width-1:0] op;
        logic [instr_width-1:0]  word;
        reset       = 1'b1;
        instruction = '0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        // Directed pass, every opcode then two unknown ones
        for (int i = 0; i < directed_count; i++) begin
            op   = (i < 15) ? kept_ops[i] : unknown_ops[i - 15];
            word = {op, 5'(i + 1), 5'(3 * i + 2), 5'(31 - i), 11'(i * 97 + 5)};
            run_instruction(word, $sformatf("directed %0d op %b", i, op));
        end

        // Random words, every other one with a kept opcode
        for (int i = 0; i < random_count; i++) begin
            word = $random(seed);
            if (i % 2 == 0)
                word[opcode_msb:opcode_lsb] = kept_ops[$unsigned($random(seed)) % 15];
            run_instruction(word, $sformatf("random %0d", i));
        end

        finish_run();
    end

endmodule

// ==== logic/control_unit.sv ====
`timescale 1ns/10ps

module control_unit
    import mips_ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [instr_width-1:0] instruction,       // Valid the cycle after pc_increment
    output logic                   pc_increment,
    output alu_op_t                alu_op,
    output logic                   alu_src,
    output logic                   reg_write_enable,
    output logic                   mem_to_reg,
    output logic                   ram_read_enable,
    output logic                   ram_write_enable,
    output reg_sel_t               reg_sel
);

    ctrl_word_t decoded;      // Zero-latency decode of the current word
    reg_sel_t   decoded_sel;

    // Combinational opcode table
    opcode_decoder u_decoder (
        .instruction (instruction),
        .decoded     (decoded),
        .decoded_sel (decoded_sel)
    );

    // Five-phase sequencer with registered outputs
    phase_controller u_phase (
        .clk              (clk),
        .reset            (reset),
        .decoded          (decoded),
        .decoded_sel      (decoded_sel),
        .pc_increment     (pc_increment),
        .alu_op           (alu_op),
        .alu_src          (alu_src),
        .reg_write_enable (reg_write_enable),
        .mem_to_reg       (mem_to_reg),
        .ram_read_enable  (ram_read_enable),
        .ram_write_enable (ram_write_enable),
        .reg_sel          (reg_sel)
    );

endmodule

// ==== logic/mips_ctrl_pkg.sv ====
package mips_ctrl_pkg;

    // Instruction word and field geometry
    localparam int instr_width    = 32;
    localparam int reg_addr_width = 5;

    localparam int opcode_msb = 31;
    localparam int opcode_lsb = 26;
    localparam int opcode_width = opcode_msb - opcode_lsb + 1; // 6 bits

    localparam int rs_msb = 25;  // First source register
    localparam int rs_lsb = 21;
    localparam int rt_msb = 20;  // Second source, or destination for I-type
    localparam int rt_lsb = 16;
    localparam int rd_msb = 15;  // Destination for R-type
    localparam int rd_lsb = 11;

    localparam int phase_count = 5; // One instruction every five cycles

    // Opcodes handled by the control unit
    typedef enum logic [opcode_width-1:0] {
        OP_ADD  = 6'b000000,
        OP_ADDU = 6'b000001,  // Decoded as ADD
        OP_SUB  = 6'b000010,
        OP_SUBU = 6'b000011,  // Decoded as SUB
        OP_SLL  = 6'b000100,
        OP_SRL  = 6'b000101,
        OP_NOR  = 6'b000110,
        OP_AND  = 6'b000111,
        OP_ADDI = 6'b001000,
        OP_OR   = 6'b001001,
        OP_ORI  = 6'b001010,
        OP_XOR  = 6'b001011,
        OP_ANDI = 6'b001100,  // Own code, no longer aliased with ADDI
        OP_LW   = 6'b100011,
        OP_SW   = 6'b101011
    } opcode_t;

    // ALU operation select
    typedef enum logic [3:0] {
        ALU_NONE = 4'b0000,  // Idle, also used for bubbles
        ALU_ADD  = 4'b0010,
        ALU_SUB  = 4'b0011,
        ALU_AND  = 4'b0100,
        ALU_OR   = 4'b0101,
        ALU_XOR  = 4'b0110,
        ALU_SLL  = 4'b1000,
        ALU_SRL  = 4'b1001,
        ALU_NOR  = 4'b1010
    } alu_op_t;

    // Register file selects for one instruction
    typedef struct packed {
        logic [reg_addr_width-1:0] read_register_1;  // rs
        logic [reg_addr_width-1:0] read_register_2;  // rt
        logic [reg_addr_width-1:0] write_register;   // rd, rt or zero
    } reg_sel_t;

    // Everything the decoder derives from the opcode, 9 bits
    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src;     // 1 selects the immediate as operand B
        logic    reg_write;   // Result goes back to the register file
        logic    mem_to_reg;  // Write-back data comes from RAM
        logic    ram_read;
        logic    ram_write;
    } ctrl_word_t;

    // Instruction phases in execution order
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4
    } phase_t;

endpackage

// ==== logic/opcode_decoder.sv ====
`timescale 1ns/10ps

module opcode_decoder
    import mips_ctrl_pkg::*;
(
    input  logic [instr_width-1:0] instruction,
    output ctrl_word_t             decoded,      // Control word for this opcode
    output reg_sel_t               decoded_sel   // Register selects for this instruction
);

    opcode_t opcode;

    logic [reg_addr_width-1:0] rs_field;
    logic [reg_addr_width-1:0] rt_field;
    logic [reg_addr_width-1:0] rd_field;

    logic r_type;  // Register-register op, writes rd
    logic i_type;  // Immediate op, writes rt

    // Field extraction
    assign opcode   = opcode_t'(instruction[opcode_msb:opcode_lsb]);
    assign rs_field = instruction[rs_msb:rs_lsb];
    assign rt_field = instruction[rt_msb:rt_lsb];
    assign rd_field = instruction[rd_msb:rd_lsb];

    always_comb begin
        decoded = '0;    // Unknown opcode leaves a bubble
        r_type  = 1'b0;
        i_type  = 1'b0;

        case (opcode)
            // R-type group, operand B from the register file
            OP_ADD, OP_ADDU: begin
                decoded.alu_op = ALU_ADD;  // ADDU shares the adder path
                r_type         = 1'b1;
            end
            OP_SUB, OP_SUBU: begin
                decoded.alu_op = ALU_SUB;
                r_type         = 1'b1;
            end
            OP_SLL: begin
                decoded.alu_op = ALU_SLL;
                r_type         = 1'b1;
            end
            OP_SRL: begin
                decoded.alu_op = ALU_SRL;
                r_type         = 1'b1;
            end
            OP_NOR: begin
                decoded.alu_op = ALU_NOR;
                r_type         = 1'b1;
            end
            OP_AND: begin
                decoded.alu_op = ALU_AND;
                r_type         = 1'b1;
            end
            OP_OR: begin
                decoded.alu_op = ALU_OR;
                r_type         = 1'b1;
            end
            OP_XOR: begin
                decoded.alu_op = ALU_XOR;
                r_type         = 1'b1;
            end

            // Immediate group
            OP_ADDI: begin
                decoded.alu_op = ALU_ADD;
                i_type         = 1'b1;
            end
            OP_ANDI: begin
                decoded.alu_op = ALU_AND;
                i_type         = 1'b1;
            end
            OP_ORI: begin
                decoded.alu_op = ALU_OR;
                i_type         = 1'b1;
            end

            // Loads and stores add base and offset
            OP_LW: begin
                decoded.alu_op     = ALU_ADD;
                decoded.alu_src    = 1'b1;  // Offset is operand B
                decoded.ram_read   = 1'b1;
                decoded.mem_to_reg = 1'b1;  // Load data goes to rt
                decoded.reg_write  = 1'b1;
            end
            OP_SW: begin
                decoded.alu_op    = ALU_ADD;
                decoded.alu_src   = 1'b1;
                decoded.ram_write = 1'b1;   // rt supplies the store data
            end

            default: ;  // Bubble
        endcase

        if (i_type) begin
            decoded.alu_src = 1'b1;  // Immediate as operand B
        end
        decoded.reg_write = decoded.reg_write | r_type | i_type;
    end

    // Selects, destination depends on the instruction class
    always_comb begin
        decoded_sel.read_register_1 = rs_field;
        decoded_sel.read_register_2 = rt_field;
        if (r_type) begin
            decoded_sel.write_register = rd_field;
        end else if (i_type || opcode == OP_LW) begin
            decoded_sel.write_register = rt_field;
        end else begin
            decoded_sel.write_register = '0;  // SW and bubbles write nothing
        end
    end

endmodule

// ==== logic/phase_controller.sv ====
`timescale 1ns/10ps

module phase_controller
    import mips_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  ctrl_word_t decoded,           // From the decoder, valid during DECODE
    input  reg_sel_t   decoded_sel,
    output logic       pc_increment,      // One-cycle request for the next instruction
    output alu_op_t    alu_op,
    output logic       alu_src,
    output logic       reg_write_enable,
    output logic       mem_to_reg,
    output logic       ram_read_enable,
    output logic       ram_write_enable,
    output reg_sel_t   reg_sel
);

    // The outputs are registered, so this register runs one phase
    // ahead of them. It holds the phase the outputs move into on
    // the next clock edge.
    phase_t phase;
    phase_t phase_next;

    ctrl_word_t ctrl_q;  // Control word of the instruction in flight
    reg_sel_t   sel_q;   // Its register selects

    // Phase sequencing, free running
    always_comb begin
        case (phase)
            FETCH:     phase_next = DECODE;
            DECODE:    phase_next = EXECUTE;
            EXECUTE:   phase_next = MEMORY;
            MEMORY:    phase_next = WRITEBACK;
            WRITEBACK: phase_next = FETCH;
            default:   phase_next = FETCH;  // Recover from an illegal code
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= FETCH;  // First edge after reset raises pc_increment
        end else begin
            phase <= phase_next;
        end
    end

    // Instruction capture at the edge that closes DECODE
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_q <= '0;
            sel_q  <= '0;
        end else if (phase == EXECUTE) begin
            ctrl_q <= decoded;      // Held for the rest of the instruction
            sel_q  <= decoded_sel;
        end
    end

    // Selects and ALU controls hold from EXECUTE until the next capture
    assign alu_op  = ctrl_q.alu_op;
    assign alu_src = ctrl_q.alu_src;
    assign reg_sel = sel_q;

    // Phase-gated enables
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_increment     <= 1'b0;
            reg_write_enable <= 1'b0;
            mem_to_reg       <= 1'b0;
            ram_read_enable  <= 1'b0;
            ram_write_enable <= 1'b0;
        end else begin
            case (phase)
                FETCH: begin
                    pc_increment     <= 1'b1;  // Request the next instruction
                    reg_write_enable <= 1'b0;  // Write-back window closes
                    mem_to_reg       <= 1'b0;
                end
                DECODE: begin
                    pc_increment <= 1'b0;  // Single-cycle pulse
                end
                MEMORY: begin
                    ram_read_enable  <= ctrl_q.ram_read;   // LW only
                    ram_write_enable <= ctrl_q.ram_write;  // SW only
                    mem_to_reg       <= ctrl_q.mem_to_reg; // Kept through write-back
                end
                WRITEBACK: begin
                    ram_read_enable  <= 1'b0;
                    ram_write_enable <= 1'b0;
                    reg_write_enable <= ctrl_q.reg_write;
                end
                default: ;  // EXECUTE only captures, see above
            endcase
        end
    end

endmodule
